//--- common/bmc_rx_pkg.sv
`default_nettype none

package bmc_rx_pkg;

  // ----------------------------------------
  // widths and limits
  // ----------------------------------------
  localparam int unsigned CNT_W     = 11;
  localparam int unsigned SYM_BITS  = 5;
  localparam int unsigned SYM_CNT_W = $clog2(SYM_BITS);

  // edge interval or threshold, in ucpd_clk cycles
  typedef logic [CNT_W-1:0] count_t;
  // one 4b5b symbol, first received bit in bit 0
  typedef logic [SYM_BITS-1:0] symbol_t;
  // bit position inside a symbol
  typedef logic [SYM_CNT_W-1:0] sym_cnt_t;

  // interval count where the line counts as idle
  localparam count_t   IDLE_LIMIT = count_t'(1023);
  localparam sym_cnt_t SYM_LAST   = sym_cnt_t'(SYM_BITS - 1);

  // bit 0 bypass, bit 1 two-sample window
  typedef logic [1:0] filt_mode_t;

  // filtered cc line as seen by the decode blocks
  typedef struct packed {
    logic level;
    logic edge_stb;
  } cc_evt_t;

  // one recovered bit
  typedef struct packed {
    logic valid;
    logic value;
  } bit_evt_t;

  typedef enum logic [1:0] {IDLE, TRAIN, HUNT, RECEIVE} rx_state_e;

endpackage

`default_nettype wire

//--- source/cc_input_filter.sv
`timescale 1ns/1ns
`default_nettype none

module cc_input_filter
  import bmc_rx_pkg::*;
(
  input  wire             ucpd_clk,
  input  wire             ic_rst_n,
  input  wire             cc_in,
  input  wire filt_mode_t filt_mode,
  output cc_evt_t         cc_evt
);

  logic [1:0] sync_q;
  logic [1:0] hist_q;
  // newest sample in bit 0
  logic [2:0] window;
  logic       filt_q;
  logic       filt_d;
  logic       filt_nxt;

  // 2-flop sync, then two more history stages
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      sync_q <= '0;
      hist_q <= '0;
    end else begin
      sync_q <= {sync_q[0], cc_in};
      hist_q <= {hist_q[0], sync_q[1]};
    end
  end

  assign window = {hist_q, sync_q[1]};

  // ----------------------------------------
  // level only moves when the window agrees
  // ----------------------------------------
  always_comb begin
    filt_nxt = filt_q;
    if (filt_mode[0]) begin
      // bypass, take the synced sample as is
      filt_nxt = sync_q[1];
    end else if (filt_mode[1]) begin
      if (window[1:0] == 2'b11) filt_nxt = 1'b1;
      else if (window[1:0] == 2'b00) filt_nxt = 1'b0;
    end else begin
      if (window == 3'b111) filt_nxt = 1'b1;
      else if (window == 3'b000) filt_nxt = 1'b0;
    end
  end

  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      filt_q <= 1'b0;
      filt_d <= 1'b0;
    end else begin
      filt_q <= filt_nxt;
      filt_d <= filt_q;
    end
  end

  // edge strobe lasts exactly one cycle
  assign cc_evt.level    = filt_q;
  assign cc_evt.edge_stb = filt_q ^ filt_d;

endmodule

`default_nettype wire

//--- source/edge_interval_timer.sv
`timescale 1ns/1ns
`default_nettype none

module edge_interval_timer
  import bmc_rx_pkg::*;
(
  input  wire          ucpd_clk,
  input  wire          ic_rst_n,
  input  wire cc_evt_t cc_evt,
  output count_t       interval,
  output logic         line_idle
);

  count_t cnt_q;

  // restart at 1 after an edge, stick at the idle limit
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      cnt_q <= '0;
    end else if (cc_evt.edge_stb) begin
      cnt_q <= count_t'(1);
    end else if (cnt_q != IDLE_LIMIT) begin
      cnt_q <= cnt_q + count_t'(1);
    end
  end

  // read in the edge cycle, this is the segment that just ended
  assign interval  = cnt_q;
  assign line_idle = (cnt_q == IDLE_LIMIT);

endmodule

`default_nettype wire

//--- source/rx_ctrl_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module rx_ctrl_fsm
  import bmc_rx_pkg::*;
(
  input  wire       ucpd_clk,
  input  wire       ic_rst_n,
  input  wire       rx_en,
  input  wire       line_idle,
  input  wire       train_done,
  input  wire       framed,
  output rx_state_e state,
  output logic      rx_active
);

  rx_state_e state_nxt;

  // ----------------------------------------
  // session sequencing
  // ----------------------------------------
  always_comb begin
    state_nxt = state;
    if (!rx_en || line_idle) begin
      // disable or idle line ends the session from any state
      state_nxt = IDLE;
    end else begin
      case (state)
        IDLE:    state_nxt = TRAIN;
        TRAIN:   if (train_done) state_nxt = HUNT;
        HUNT:    if (framed) state_nxt = RECEIVE;
        RECEIVE: state_nxt = RECEIVE;
        default: state_nxt = IDLE;
      endcase
    end
  end

  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // symbols only flow in receive
  assign rx_active = (state == RECEIVE);

endmodule

`default_nettype wire

//--- bmc_decode/ui_trainer.sv
`timescale 1ns/1ns
`default_nettype none

module ui_trainer
  import bmc_rx_pkg::*;
(
  input  wire            ucpd_clk,
  input  wire            ic_rst_n,
  input  wire rx_state_e state,
  input  wire cc_evt_t   cc_evt,
  input  wire count_t    interval,
  output logic           train_done,
  output count_t         threshold
);

  logic             in_train_q;
  logic             started;
  logic [1:0]       idx;
  count_t           ui_a;
  count_t           ui_b;
  logic [CNT_W+1:0] sum3;
  logic [CNT_W+2:0] sum_x3;
  logic             accept;

  // ----------------------------------------
  // threshold = 3/8 of a + b + c
  // ----------------------------------------
  // c is the interval ending on the current edge
  assign sum3   = {2'b00, ui_a} + {2'b00, ui_b} + {2'b00, interval};
  assign sum_x3 = {1'b0, sum3} + {sum3, 1'b0};
  // a or c strictly largest, b largest means a lost leading edge
  assign accept = ((ui_a > ui_b) && (ui_a > interval)) ||
                  ((interval > ui_a) && (interval > ui_b));

  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      in_train_q <= 1'b0;
      started    <= 1'b0;
      idx        <= 2'd0;
      train_done <= 1'b0;
      threshold  <= '0;
    end else begin
      in_train_q <= (state == TRAIN);
      train_done <= 1'b0;
      // fresh threshold on every entry into train
      if ((state == TRAIN) && !in_train_q) threshold <= '0;
      if (state != TRAIN) begin
        started <= 1'b0;
        idx     <= 2'd0;
      end else if (cc_evt.edge_stb) begin
        if (!started) begin
          // first edge only opens the first interval
          started <= 1'b1;
        end else if (idx == 2'd2) begin
          // retry on the next three intervals if rejected
          idx <= 2'd0;
          if (accept) begin
            train_done <= 1'b1;
            threshold  <= sum_x3[CNT_W+2:3];
          end
        end else begin
          idx <= idx + 2'd1;
        end
      end
    end
  end

  // captured interval counts
  always_ff @(posedge ucpd_clk) begin
    if ((state == TRAIN) && cc_evt.edge_stb && started) begin
      if (idx == 2'd0) ui_a <= interval;
      if (idx == 2'd1) ui_b <= interval;
    end
  end

endmodule

`default_nettype wire

//--- bmc_decode/bmc_bit_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module bmc_bit_decoder
  import bmc_rx_pkg::*;
(
  input  wire            ucpd_clk,
  input  wire            ic_rst_n,
  input  wire rx_state_e state,
  input  wire cc_evt_t   cc_evt,
  input  wire count_t    interval,
  input  wire count_t    threshold,
  output logic           framed,
  output logic           sym_done,
  output symbol_t        sym_data
);

  logic     decoding;
  logic     short_iv;
  logic     pending;
  logic     have_prev;
  logic     prev_bit;
  logic     last_bit;
  sym_cnt_t bit_cnt;
  symbol_t  sym_sr;
  bit_evt_t bit_evt;

  // ----------------------------------------
  // bit recovery
  // ----------------------------------------
  assign decoding = (state == HUNT) || (state == RECEIVE);
  assign short_iv = (interval <= threshold);

  // long gives 0, second short of a pair gives 1
  assign bit_evt.valid = decoding && cc_evt.edge_stb && (!short_iv || pending);
  assign bit_evt.value = short_iv;
  assign last_bit      = (bit_cnt == SYM_LAST);

  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      pending   <= 1'b0;
      have_prev <= 1'b0;
      prev_bit  <= 1'b0;
      bit_cnt   <= '0;
      framed    <= 1'b0;
      sym_done  <= 1'b0;
    end else begin
      framed   <= 1'b0;
      sym_done <= 1'b0;
      // lone short followed by long is dropped here
      if (!decoding) pending <= 1'b0;
      else if (cc_evt.edge_stb) pending <= short_iv && !pending;
      if (state != HUNT) have_prev <= 1'b0;
      if (bit_evt.valid && (state == HUNT)) begin
        prev_bit  <= bit_evt.value;
        have_prev <= 1'b1;
        // equal pair marks bits 0 and 1 of symbol 0
        if (have_prev && (prev_bit == bit_evt.value)) begin
          framed    <= 1'b1;
          have_prev <= 1'b0;
          bit_cnt   <= sym_cnt_t'(2);
        end
      end else if (bit_evt.valid && (state == RECEIVE)) begin
        if (last_bit) begin
          sym_done <= 1'b1;
          bit_cnt  <= '0;
        end else begin
          bit_cnt <= bit_cnt + sym_cnt_t'(1);
        end
      end
    end
  end

  // shift right so the first bit ends in bit 0
  always_ff @(posedge ucpd_clk) begin
    if (bit_evt.valid && (state == HUNT)) begin
      sym_sr <= {bit_evt.value, prev_bit, sym_sr[SYM_BITS-3:0]};
    end else if (bit_evt.valid && (state == RECEIVE)) begin
      sym_sr <= {bit_evt.value, sym_sr[SYM_BITS-1:1]};
      if (last_bit) sym_data <= {bit_evt.value, sym_sr[SYM_BITS-1:1]};
    end
  end

endmodule

`default_nettype wire

//--- source/symbol_out_port.sv
`timescale 1ns/1ns
`default_nettype none

module symbol_out_port
  import bmc_rx_pkg::*;
(
  input  wire            ucpd_clk,
  input  wire            ic_rst_n,
  input  wire rx_state_e state,
  input  wire            sym_done,
  input  wire symbol_t   sym_data,
  input  wire            sym_ack,
  output logic           sym_req,
  output symbol_t        sym,
  output logic           sym_overrun
);

  // four-phase handshake phases
  typedef enum logic [1:0] {FREE, REQ, RELEASE} hs_phase_e;

  hs_phase_e phase;
  logic      idle_q;
  logic      take;

  // accept only with req and ack both low
  assign take    = sym_done && (phase == FREE) && !sym_ack;
  assign sym_req = (phase == REQ);

  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      phase       <= FREE;
      idle_q      <= 1'b1;
      sym_overrun <= 1'b0;
    end else begin
      idle_q <= (state == IDLE);
      case (phase)
        FREE:    if (take) phase <= REQ;
        // drop req the cycle after ack is seen
        REQ:     if (sym_ack) phase <= RELEASE;
        RELEASE: if (!sym_ack) phase <= FREE;
        default: phase <= FREE;
      endcase
      // sticky until a new session starts
      if (idle_q && (state != IDLE)) sym_overrun <= 1'b0;
      else if (sym_done && !take) sym_overrun <= 1'b1;
    end
  end

  // symbol stays put while req is up
  always_ff @(posedge ucpd_clk) begin
    if (take) sym <= sym_data;
  end

endmodule

`default_nettype wire

//--- source/ucpd_bmc_rx.sv
`timescale 1ns/1ns
`default_nettype none

module ucpd_bmc_rx
  import bmc_rx_pkg::*;
(
  input  wire             ucpd_clk,
  input  wire             ic_rst_n,
  input  wire             cc_in,
  input  wire filt_mode_t filt_mode,
  input  wire             rx_en,
  input  wire             sym_ack,
  output logic            sym_req,
  output symbol_t         sym,
  output logic            sym_overrun,
  output logic            rx_active
);

  cc_evt_t   cc_evt;
  count_t    interval;
  count_t    threshold;
  logic      line_idle;
  logic      train_done;
  logic      framed;
  logic      sym_done;
  symbol_t   sym_data;
  rx_state_e state;

  // ----------------------------------------
  // line conditioning and timing
  // ----------------------------------------
  cc_input_filter u_cc_input_filter (
    .ucpd_clk  (ucpd_clk),
    .ic_rst_n  (ic_rst_n),
    .cc_in     (cc_in),
    .filt_mode (filt_mode),
    .cc_evt    (cc_evt)
  );

  edge_interval_timer u_edge_interval_timer (
    .ucpd_clk  (ucpd_clk),
    .ic_rst_n  (ic_rst_n),
    .cc_evt    (cc_evt),
    .interval  (interval),
    .line_idle (line_idle)
  );

  // session control
  rx_ctrl_fsm u_rx_ctrl_fsm (
    .ucpd_clk   (ucpd_clk),
    .ic_rst_n   (ic_rst_n),
    .rx_en      (rx_en),
    .line_idle  (line_idle),
    .train_done (train_done),
    .framed     (framed),
    .state      (state),
    .rx_active  (rx_active)
  );

  // ----------------------------------------
  // training, decode and symbol output
  // ----------------------------------------
  ui_trainer u_ui_trainer (
    .ucpd_clk   (ucpd_clk),
    .ic_rst_n   (ic_rst_n),
    .state      (state),
    .cc_evt     (cc_evt),
    .interval   (interval),
    .train_done (train_done),
    .threshold  (threshold)
  );

  bmc_bit_decoder u_bmc_bit_decoder (
    .ucpd_clk  (ucpd_clk),
    .ic_rst_n  (ic_rst_n),
    .state     (state),
    .cc_evt    (cc_evt),
    .interval  (interval),
    .threshold (threshold),
    .framed    (framed),
    .sym_done  (sym_done),
    .sym_data  (sym_data)
  );

  symbol_out_port u_symbol_out_port (
    .ucpd_clk    (ucpd_clk),
    .ic_rst_n    (ic_rst_n),
    .state       (state),
    .sym_done    (sym_done),
    .sym_data    (sym_data),
    .sym_ack     (sym_ack),
    .sym_req     (sym_req),
    .sym         (sym),
    .sym_overrun (sym_overrun)
  );

endmodule

`default_nettype wire

//--- bench/ucpd_bmc_rx_assert.sv
`timescale 1ns/1ns
`default_nettype none

module ucpd_bmc_rx_assert
  import bmc_rx_pkg::*;
(
  input wire            ucpd_clk,
  input wire            ic_rst_n,
  input wire            sym_req,
  input wire            sym_ack,
  input wire symbol_t   sym,
  input wire rx_state_e state
);

  // ----------------------------------------
  // symbol handshake
  // ----------------------------------------
  // held symbol frozen until ack
  a_sym_stable : assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    (sym_req && !sym_ack) |=> $stable(sym))
    else $error("sym changed while sym_req high and sym_ack low");

  // new req only from a released ack
  a_req_no_ack : assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    $rose(sym_req) |-> !$past(sym_ack))
    else $error("sym_req rose while sym_ack was high");

  // session always passes through train, state driven by rx_ctrl_fsm
  a_idle_exit : assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n)
    (state == IDLE) |=> ((state == IDLE) || (state == TRAIN)))
    else $error("state left IDLE for something other than TRAIN");

endmodule

bind symbol_out_port ucpd_bmc_rx_assert u_bmc_rx_assert (
  .ucpd_clk (ucpd_clk),
  .ic_rst_n (ic_rst_n),
  .sym_req  (sym_req),
  .sym_ack  (sym_ack),
  .sym      (sym),
  .state    (state)
);

`default_nettype wire

//--- bench/tb_ucpd_bmc_rx.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ucpd_bmc_rx
  import bmc_rx_pkg::*;
();

  localparam int HALF_PERIOD = 50;
  localparam int N_RAND      = 12;
  // idle tail well past the idle limit
  localparam int TAIL_CYCLES = int'(IDLE_LIMIT) + 77;
  // longest frame is h = 20 with preamble, 13 symbols and tail
  localparam int FRAME_MAX   = 64 * 2 * 20 + 13 * 10 * 20 + TAIL_CYCLES + 1;
  localparam int N_FRAMES    = 12;
  localparam int WATCHDOG    = N_FRAMES * FRAME_MAX * 2 + 10000;

  logic       ucpd_clk;
  logic       ic_rst_n;
  logic       cc_in;
  filt_mode_t filt_mode;
  logic       rx_en;
  logic       sym_ack;
  logic       sym_req;
  symbol_t    sym;
  logic       sym_overrun;
  logic       rx_active;

  // reference model of symbols still owed by the receiver
  symbol_t expected_q[$];
  int      err_count;
  int      test_errs;
  int      test_num;
  logic    line_lvl;
  logic    hold_ack;

  ucpd_bmc_rx ucpd_bmc_rx_inst (
    .ucpd_clk    (ucpd_clk),
    .ic_rst_n    (ic_rst_n),
    .cc_in       (cc_in),
    .filt_mode   (filt_mode),
    .rx_en       (rx_en),
    .sym_ack     (sym_ack),
    .sym_req     (sym_req),
    .sym         (sym),
    .sym_overrun (sym_overrun),
    .rx_active   (rx_active)
  );

  initial begin
    ucpd_clk = 1'b0;
    forever #HALF_PERIOD ucpd_clk = ~ucpd_clk;
  end

  // ----------------------------------------
  // checking helpers
  // ----------------------------------------
  task automatic count_error();
    err_count++;
    test_errs++;
  endtask

  task automatic report_error(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    count_error();
  endtask

  task automatic check_sig(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
      count_error();
    end
  endtask

  task automatic close_test(input string name);
    test_num++;
    if (test_errs == 0) $display("test %0d %s: ok", test_num, name);
    else $display("test %0d %s: %0d errors", test_num, name, test_errs);
    test_errs = 0;
  endtask

  // ----------------------------------------
  // bmc line stimulus
  // ----------------------------------------
  task automatic hold_line(input logic lvl, input int n);
    repeat (n) begin
      @(posedge ucpd_clk);
      #10;
      cc_in = lvl;
    end
  endtask

  // every bit opens with a transition and a one also flips mid bit
  task automatic send_bit(input logic b, input int h, input logic glitch);
    line_lvl = ~line_lvl;
    if (b) begin
      hold_line(line_lvl, h);
      line_lvl = ~line_lvl;
      hold_line(line_lvl, h);
    end else if (glitch) begin
      // one cycle spike in the middle of the long segment
      hold_line(line_lvl, h);
      hold_line(~line_lvl, 1);
      hold_line(line_lvl, h - 1);
    end else begin
      hold_line(line_lvl, 2 * h);
    end
  endtask

  task automatic send_frame(input int h, input int n_rand, input logic expect_rx,
                            input logic glitch, input int drop_sym);
    symbol_t syms[$];
    syms.push_back(symbol_t'(0));
    for (int k = 0; k < n_rand; k++) syms.push_back(symbol_t'($urandom % 32));
    if (expect_rx) begin
      foreach (syms[k]) expected_q.push_back(syms[k]);
    end
    // alternating preamble with 0 first and 1 last
    for (int i = 0; i < 64; i++) send_bit(i[0], h, glitch);
    foreach (syms[k]) begin
      for (int j = 0; j < SYM_BITS; j++) begin
        if ((k == drop_sym) && (j == 2)) begin
          // session torn down mid symbol
          rx_en = 1'b0;
          if (expected_q.size() != syms.size() - drop_sym)
            report_error("symbols before the rx_en drop were not all delivered");
          expected_q.delete();
        end
        send_bit(syms[k][j], h, glitch);
      end
    end
    // closing edge ends the last bit and then the line rests
    line_lvl = ~line_lvl;
    hold_line(line_lvl, TAIL_CYCLES);
  endtask

  task automatic frame_done_checks();
    if (expected_q.size() != 0) begin
      report_error($sformatf("%0d sent symbols never arrived", expected_q.size()));
      expected_q.delete();
    end
    check_sig("sym_overrun", sym_overrun, 1'b0);
    check_sig("rx_active", rx_active, 1'b0);
  endtask

  task automatic wait_req_low();
    for (int i = 0; (i < 50) && sym_req; i++) begin
      @(posedge ucpd_clk);
      #10;
    end
    if (sym_req) report_error("sym_req stayed high after ack was given");
  endtask

  function automatic int rand_half();
    return 8 + int'($urandom % 13);
  endfunction

  // ----------------------------------------
  // consumer side of the symbol handshake
  // ----------------------------------------
  initial begin : consumer
    logic    req_q;
    int      ack_wait;
    symbol_t exp_sym;
    req_q    = 1'b0;
    ack_wait = 0;
    forever begin
      @(posedge ucpd_clk);
      #10;
      if (sym_req && !req_q) begin
        if (expected_q.size() == 0) begin
          report_error($sformatf("unexpected symbol %h on sym", sym));
        end else begin
          exp_sym = expected_q.pop_front();
          if (sym !== exp_sym) begin
            $display("mismatch at %0t ns: sym got %h expected %h", $time, sym, exp_sym);
            count_error();
          end
        end
        ack_wait = int'($urandom % 7);
      end
      req_q = sym_req;
      // ack drops once req is seen low
      if (sym_ack) begin
        if (!sym_req) sym_ack = 1'b0;
      end else if (sym_req && !hold_ack) begin
        if (ack_wait == 0) sym_ack = 1'b1;
        else ack_wait--;
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG) @(posedge ucpd_clk);
    $display("watchdog expired after %0d cycles, run did not complete", WATCHDOG);
    $display("Simulation failed");
    $finish;
  end

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin : main
    int unsigned rnd;
    rnd       = $urandom(32'hf335_844b);
    cc_in     = 1'b0;
    rx_en     = 1'b0;
    sym_ack   = 1'b0;
    filt_mode = 2'b00;
    ic_rst_n  = 1'b0;
    line_lvl  = 1'b0;
    hold_ack  = 1'b0;
    err_count = 0;
    test_errs = 0;
    test_num  = 0;
    repeat (4) @(posedge ucpd_clk);
    #10;
    ic_rst_n = 1'b1;

    check_sig("sym_req", sym_req, 1'b0);
    check_sig("sym_overrun", sym_overrun, 1'b0);
    check_sig("rx_active", rx_active, 1'b0);
    // let the timer reach idle before any frame
    hold_line(line_lvl, TAIL_CYCLES);
    send_frame(rand_half(), 4, 1'b0, 1'b0, -1);
    check_sig("rx_active", rx_active, 1'b0);
    check_sig("sym_req", sym_req, 1'b0);
    close_test("receiver disabled");

    rx_en = 1'b1;
    for (int f = 0; f < 3; f++) begin
      send_frame(rand_half(), N_RAND, 1'b1, 1'b0, -1);
      frame_done_checks();
    end
    close_test("3-sample random frames");

    filt_mode = 2'b10;
    send_frame(rand_half(), N_RAND, 1'b1, 1'b0, -1);
    frame_done_checks();
    filt_mode = 2'b01;
    send_frame(rand_half(), N_RAND, 1'b1, 1'b0, -1);
    frame_done_checks();
    // one-cycle glitches must be filtered out by the 3-sample window
    filt_mode = 2'b00;
    send_frame(rand_half(), N_RAND, 1'b1, 1'b1, -1);
    frame_done_checks();
    close_test("filter modes and glitches");

    send_frame(rand_half(), N_RAND, 1'b1, 1'b0, -1);
    frame_done_checks();
    send_frame(rand_half(), N_RAND, 1'b1, 1'b0, -1);
    frame_done_checks();
    close_test("session restart");

    hold_ack = 1'b1;
    send_frame(rand_half(), 4, 1'b1, 1'b0, -1);
    check_sig("sym_overrun", sym_overrun, 1'b1);
    check_sig("sym_req", sym_req, 1'b1);
    if (sym !== symbol_t'(0)) begin
      $display("mismatch at %0t ns: sym got %h expected %h", $time, sym, symbol_t'(0));
      count_error();
    end
    // later symbols were dropped by the port
    expected_q.delete();
    hold_ack = 1'b0;
    wait_req_low();
    send_frame(rand_half(), N_RAND, 1'b1, 1'b0, -1);
    frame_done_checks();
    close_test("back-pressure overrun");

    send_frame(rand_half(), N_RAND, 1'b1, 1'b0, 6);
    check_sig("rx_active", rx_active, 1'b0);
    check_sig("sym_req", sym_req, 1'b0);
    rx_en = 1'b1;
    close_test("rx_en drop mid frame");

    $display("%0d tests run, %0d errors", test_num, err_count);
    if (err_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
common/bmc_rx_pkg.sv
source/cc_input_filter.sv
source/edge_interval_timer.sv
source/rx_ctrl_fsm.sv
bmc_decode/ui_trainer.sv
bmc_decode/bmc_bit_decoder.sv
source/symbol_out_port.sv
source/ucpd_bmc_rx.sv
bench/ucpd_bmc_rx_assert.sv
bench/tb_ucpd_bmc_rx.sv

//--- Makefile
TOP := tb_ucpd_bmc_rx

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f --Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir
